/* cgra_cfg.svh */
// CGRA configuration macros
// array geometry and datapath widths shared by the package and the RTL

`ifndef CGRA_CFG_SVH
`define CGRA_CFG_SVH

// PE rows, north to south
`define CGRA_ROWS 4

// PE columns, one input and one output lane each
`define CGRA_COLS 4

// operand width in bits
`define CGRA_DATA_WIDTH 32

// PE immediate width in bits
`define CGRA_IMM_WIDTH 16

`endif

/* cgra_pkg.sv */
// CGRA types
// datapath, configuration word and loader state types for the array

`include "cgra_cfg.svh"

package cgra_pkg;

    typedef logic [`CGRA_DATA_WIDTH-1:0] data_t;

    // zero-extended to data_t before use
    typedef logic [`CGRA_IMM_WIDTH-1:0] imm_t;

    typedef enum logic [1:0] {
        op_pass = 2'd0,
        op_add  = 2'd1,
        op_sub  = 2'd2,
        op_xor  = 2'd3
    } pe_op_t;

    // op in the top two bits, immediate below
    typedef logic [`CGRA_IMM_WIDTH+1:0] cfg_word_t;

    // row * cols + column, row 0 at the north edge
    typedef logic [3:0] pe_idx_t;

    typedef enum logic [1:0] {
        cfg_idle  = 2'd0,
        cfg_load  = 2'd1,
        cfg_ready = 2'd2,
        cfg_run   = 2'd3
    } cfg_state_t;

endpackage

/* cgra_cfg_fsm.sv */
// CGRA loader FSM
// sequences configuration loading and execution of the array

`timescale 1ns/1ps

module cgra_cfg_fsm (
    input  logic clk,
    input  logic rst,
    input  logic bitstream_enable,
    input  logic cfg_valid,
    input  logic execute,
    input  logic last_word,
    output logic cnt_clear,
    output logic cfg_accept,
    output logic run,
    output logic cfg_done
);

    import cgra_pkg::*;

    cfg_state_t state;
    cfg_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cfg_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        cnt_clear  = 1'b0;
        cfg_accept = 1'b0;
        case (state)
            cfg_idle: begin
                if (bitstream_enable) begin
                    cnt_clear  = 1'b1;
                    state_next = cfg_load;
                end
            end
            cfg_load: begin
                cfg_accept = cfg_valid;
                // leave once the sixteenth word is taken
                if (cfg_valid && last_word) begin
                    state_next = cfg_ready;
                end
            end
            cfg_ready: begin
                if (bitstream_enable) begin
                    cnt_clear  = 1'b1;
                    state_next = cfg_load;
                end else if (execute) begin
                    state_next = cfg_run;
                end
            end
            cfg_run: begin
                if (bitstream_enable) begin
                    cnt_clear  = 1'b1;
                    state_next = cfg_load;
                end else if (!execute) begin
                    state_next = cfg_ready;
                end
            end
            default: begin
                state_next = cfg_idle;
            end
        endcase
    end

    assign cfg_done = (state == cfg_ready) || (state == cfg_run);
    assign run      = (state == cfg_run);

endmodule

/* cgra_cfg_counter.sv */
// CGRA configuration counter
// steers each accepted configuration word to the next PE in order

`timescale 1ns/1ps

`include "cgra_cfg.svh"

module cgra_cfg_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              cnt_clear,
    input  logic              cfg_accept,
    output cgra_pkg::pe_idx_t pe_idx,
    output logic              last_word
);

    import cgra_pkg::*;

    localparam pe_idx_t LAST_IDX = pe_idx_t'(`CGRA_ROWS * `CGRA_COLS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            pe_idx <= '0;
        end else if (cnt_clear) begin
            pe_idx <= '0;
        end else if (cfg_accept) begin
            // wraps to 0 after the last PE
            pe_idx <= (pe_idx == LAST_IDX) ? '0 : pe_idx + 1'b1;
        end
    end

    assign last_word = (pe_idx == LAST_IDX);

endmodule

/* cgra_pe.sv */
// CGRA processing element
// applies its configured op and immediate to each operand and holds
// the result in a one-entry elastic output register

`timescale 1ns/1ps

`include "cgra_cfg.svh"

module cgra_pe (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  logic                cfg_write,
    input  cgra_pkg::cfg_word_t cfg_word,
    input  cgra_pkg::data_t     in_data,
    input  logic                in_valid,
    output logic                in_ready,
    output cgra_pkg::data_t     out_data,
    output logic                out_valid,
    input  logic                out_ready
);

    import cgra_pkg::*;

    pe_op_t op;
    imm_t   imm;
    logic   configured;
    data_t  result;
    logic   in_fire;

    // configuration register
    always_ff @(posedge clk) begin
        if (rst) begin
            op         <= op_pass;
            imm        <= '0;
            configured <= 1'b0;
        end else if (cfg_write) begin
            op         <= pe_op_t'(cfg_word[`CGRA_IMM_WIDTH +: 2]);
            imm        <= cfg_word[`CGRA_IMM_WIDTH-1:0];
            configured <= 1'b1;
        end
    end

    always_comb begin
        case (op)
            op_add:  result = in_data + data_t'(imm);
            op_sub:  result = in_data - data_t'(imm);
            op_xor:  result = in_data ^ data_t'(imm);
            default: result = in_data;
        endcase
    end

    // space when empty or draining this cycle
    assign in_ready = run && configured && (!out_valid || out_ready);
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data <= result;
        end
    end

endmodule

/* cgra_array.sv */
// CGRA PE mesh
// decodes configuration writes and chains PEs north to south per column

`timescale 1ns/1ps

`include "cgra_cfg.svh"

module cgra_array (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       run,
    input  logic                                       cfg_accept,
    input  cgra_pkg::pe_idx_t                          pe_idx,
    input  cgra_pkg::cfg_word_t                        cfg_word,
    input  logic [`CGRA_COLS*`CGRA_DATA_WIDTH-1:0]     data_in,
    input  logic [`CGRA_COLS-1:0]                      data_in_valid,
    output logic [`CGRA_COLS-1:0]                      data_in_ready,
    output logic [`CGRA_COLS*`CGRA_DATA_WIDTH-1:0]     data_out,
    output logic [`CGRA_COLS-1:0]                      data_out_valid,
    input  logic [`CGRA_COLS-1:0]                      data_out_ready
);

    import cgra_pkg::*;

    localparam int ROWS   = `CGRA_ROWS;
    localparam int COLS   = `CGRA_COLS;
    localparam int DATA_W = `CGRA_DATA_WIDTH;

    logic [ROWS*COLS-1:0] cfg_write;

    // link row r feeds PE row r, row ROWS is the south edge
    data_t link_data  [0:ROWS][0:COLS-1];
    logic  link_valid [0:ROWS][0:COLS-1];
    logic  link_ready [0:ROWS][0:COLS-1];

    // one-hot write enable per PE
    always_comb begin
        for (int i = 0; i < ROWS * COLS; i++) begin
            cfg_write[i] = cfg_accept && (pe_idx == pe_idx_t'(i));
        end
    end

    for (genvar c = 0; c < COLS; c++) begin : g_edge
        // north edge
        assign link_data[0][c]  = data_in[c*DATA_W +: DATA_W];
        assign link_valid[0][c] = data_in_valid[c];
        assign data_in_ready[c] = link_ready[0][c];

        // south edge
        assign data_out[c*DATA_W +: DATA_W] = link_data[ROWS][c];
        assign data_out_valid[c]            = link_valid[ROWS][c];
        assign link_ready[ROWS][c]          = data_out_ready[c];
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            cgra_pe u_pe (
                .clk       (clk),
                .rst       (rst),
                .run       (run),
                .cfg_write (cfg_write[r*COLS+c]),
                .cfg_word  (cfg_word),
                .in_data   (link_data[r][c]),
                .in_valid  (link_valid[r][c]),
                .in_ready  (link_ready[r][c]),
                .out_data  (link_data[r+1][c]),
                .out_valid (link_valid[r+1][c]),
                .out_ready (link_ready[r+1][c])
            );
        end
    end

endmodule

/* cgra_top.sv */
// CGRA top level
// 4x4 array with a serial configuration loader on a valid/ready
// streaming datapath

`timescale 1ns/1ps

`include "cgra_cfg.svh"

module cgra_top (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       bitstream_enable,
    input  cgra_pkg::cfg_word_t                        cfg_word,
    input  logic                                       cfg_valid,
    input  logic                                       execute,
    output logic                                       cfg_done,
    input  logic [`CGRA_COLS*`CGRA_DATA_WIDTH-1:0]     data_in,
    input  logic [`CGRA_COLS-1:0]                      data_in_valid,
    output logic [`CGRA_COLS-1:0]                      data_in_ready,
    output logic [`CGRA_COLS*`CGRA_DATA_WIDTH-1:0]     data_out,
    output logic [`CGRA_COLS-1:0]                      data_out_valid,
    input  logic [`CGRA_COLS-1:0]                      data_out_ready
);

    import cgra_pkg::*;

    logic    cnt_clear;
    logic    cfg_accept;
    logic    run;
    logic    last_word;
    pe_idx_t pe_idx;

    cgra_cfg_fsm u_cfg_fsm (
        .clk              (clk),
        .rst              (rst),
        .bitstream_enable (bitstream_enable),
        .cfg_valid        (cfg_valid),
        .execute          (execute),
        .last_word        (last_word),
        .cnt_clear        (cnt_clear),
        .cfg_accept       (cfg_accept),
        .run              (run),
        .cfg_done         (cfg_done)
    );

    cgra_cfg_counter u_cfg_counter (
        .clk        (clk),
        .rst        (rst),
        .cnt_clear  (cnt_clear),
        .cfg_accept (cfg_accept),
        .pe_idx     (pe_idx),
        .last_word  (last_word)
    );

    cgra_array u_array (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .cfg_accept     (cfg_accept),
        .pe_idx         (pe_idx),
        .cfg_word       (cfg_word),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

endmodule

/* tb_cgra.sv */
// CGRA testbench
// loads two configurations, streams operands through every lane and
// checks results, ordering and back-pressure against a reference model

`timescale 1ns/1ps

`include "cgra_cfg.svh"

module tb_cgra;

    import cgra_pkg::*;

    localparam int ROWS         = `CGRA_ROWS;
    localparam int COLS         = `CGRA_COLS;
    localparam int DATA_W       = `CGRA_DATA_WIDTH;
    localparam int IMM_W        = `CGRA_IMM_WIDTH;
    localparam int N_PE         = ROWS * COLS;
    localparam int N_ROWS_TAB   = 8;
    localparam int TIMEOUT      = 2000;
    localparam int READY_ALL    = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_NONE   = 2;

    logic                     clk;
    logic                     rst;
    logic                     bitstream_enable;
    cfg_word_t                cfg_word;
    logic                     cfg_valid;
    logic                     execute;
    logic                     cfg_done;
    logic [COLS*DATA_W-1:0]   data_in;
    logic [COLS-1:0]          data_in_valid;
    logic [COLS-1:0]          data_in_ready;
    logic [COLS*DATA_W-1:0]   data_out;
    logic [COLS-1:0]          data_out_valid;
    logic [COLS-1:0]          data_out_ready;

    // one configuration per phase, index = row * COLS + column
    cfg_word_t cfg_table [0:1][0:N_PE-1] = '{
        '{ {op_add, 16'h0010}, {op_sub, 16'h0001}, {op_xor, 16'hA5A5}, {op_pass, 16'h0000},
           {op_xor, 16'h00FF}, {op_add, 16'hFFFF}, {op_sub, 16'h8000}, {op_add, 16'h0001},
           {op_sub, 16'h0100}, {op_xor, 16'h1234}, {op_add, 16'h7FFF}, {op_sub, 16'hFFFF},
           {op_pass, 16'h0000}, {op_sub, 16'h0002}, {op_xor, 16'hFFFF}, {op_add, 16'h4321} },
        '{ {op_sub, 16'h0003}, {op_xor, 16'hFFFF}, {op_pass, 16'h0000}, {op_add, 16'h8000},
           {op_add, 16'hFFFF}, {op_pass, 16'h0000}, {op_xor, 16'h0F0F}, {op_sub, 16'h0010},
           {op_xor, 16'h5A5A}, {op_sub, 16'h7FFF}, {op_add, 16'h0001}, {op_pass, 16'h0000},
           {op_add, 16'h0002}, {op_add, 16'h1111}, {op_sub, 16'hFFFF}, {op_xor, 16'h00F0} }
    };

    // operand rows: lane and value, chosen around the wraparound points
    int    row_lane  [0:N_ROWS_TAB-1] = '{0, 1, 2, 3, 0, 1, 2, 3};
    data_t row_value [0:N_ROWS_TAB-1] = '{
        32'hFFFF_FFF8, 32'h0000_0000, 32'h0000_7FFF, 32'hFFFF_FFFF,
        32'h0000_0000, 32'h0000_0001, 32'h8000_0000, 32'h1234_5678
    };

    cfg_word_t   active_cfg [0:N_PE-1];
    data_t       send_q [COLS][$];
    data_t       exp_q [COLS][$];
    data_t       last_out [0:COLS-1];
    logic        held [0:COLS-1];
    logic        exec_prev;
    logic [31:0] lfsr = 32'd50;

    cgra_top dut (
        .clk              (clk),
        .rst              (rst),
        .bitstream_enable (bitstream_enable),
        .cfg_word         (cfg_word),
        .cfg_valid        (cfg_valid),
        .execute          (execute),
        .cfg_done         (cfg_done),
        .data_in          (data_in),
        .data_in_valid    (data_in_valid),
        .data_in_ready    (data_in_ready),
        .data_out         (data_out),
        .data_out_valid   (data_out_valid),
        .data_out_ready   (data_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        b;
        value = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            value = {value[30:0], b};
        end
        return value;
    endfunction

    function automatic data_t apply_op(input cfg_word_t w, input data_t x);
        data_t imm;
        imm = data_t'(w[IMM_W-1:0]);
        case (pe_op_t'(w[IMM_W +: 2]))
            op_add:  return x + imm;
            op_sub:  return x - imm;
            op_xor:  return x ^ imm;
            default: return x;
        endcase
    endfunction

    // column ops from north to south
    function automatic data_t expected_for(input int lane, input data_t x);
        data_t v;
        v = x;
        for (int r = 0; r < ROWS; r++) begin
            v = apply_op(active_cfg[r*COLS+lane], v);
        end
        return v;
    endfunction

    function automatic logic lanes_empty();
        for (int c = 0; c < COLS; c++) begin
            if (send_q[c].size() != 0 || exp_q[c].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: %s got 0x%08h expected 0x%08h",
                               $time, name, got, exp));
        end
    endtask

    task automatic load_config(input int phase);
        int n;
        @(negedge clk);
        bitstream_enable = 1'b1;
        execute          = 1'b0;
        exec_prev        = 1'b0;
        cfg_valid        = 1'b0;
        for (int i = 0; i < N_PE; i++) begin
            @(negedge clk);
            check("cfg_done", data_t'(cfg_done), '0);
            cfg_valid = 1'b1;
            cfg_word  = cfg_table[phase][i];
            // enable drops with the last word, else the loader restarts
            if (i == N_PE - 1) begin
                bitstream_enable = 1'b0;
            end
        end
        n = 0;
        do begin
            @(negedge clk);
            cfg_valid = 1'b0;
            n++;
            if (n > TIMEOUT) begin
                fail_run("timeout: cfg_done never rose after the configuration stream");
            end
        end while (!cfg_done);
        check("cfg_done latency", data_t'(n), data_t'(1));
        for (int i = 0; i < N_PE; i++) begin
            active_cfg[i] = cfg_table[phase][i];
        end
    endtask

    task automatic step(input int mode, input logic exec);
        logic [31:0]     r;
        logic [COLS-1:0] rdy;
        data_t           lane_out;
        data_t           exp;
        data_t           sent;
        @(negedge clk);
        for (int c = 0; c < COLS; c++) begin
            if (held[c]) begin
                check($sformatf("data_out_valid[%0d]", c), data_t'(data_out_valid[c]), 1);
                check($sformatf("data_out[%0d]", c), data_out[c*DATA_W +: DATA_W], last_out[c]);
            end
        end
        case (mode)
            READY_ALL: rdy = '1;
            READY_RANDOM: begin
                r   = rand_bits(COLS);
                rdy = r[COLS-1:0];
            end
            default: rdy = '0;
        endcase
        data_out_ready = rdy;
        execute        = exec;
        for (int c = 0; c < COLS; c++) begin
            if (send_q[c].size() != 0) begin
                data_in_valid[c]              = 1'b1;
                data_in[c*DATA_W +: DATA_W]   = send_q[c][0];
            end else begin
                data_in_valid[c]              = 1'b0;
                data_in[c*DATA_W +: DATA_W]   = '0;
            end
        end
        #1;
        for (int c = 0; c < COLS; c++) begin
            lane_out = data_out[c*DATA_W +: DATA_W];
            if (data_out_valid[c] && data_out_ready[c]) begin
                if (exp_q[c].size() == 0) begin
                    fail_run($sformatf("lane %0d delivered a word that was never sent", c));
                end
                exp = exp_q[c].pop_front();
                check($sformatf("data_out[%0d]", c), lane_out, exp);
                held[c] = 1'b0;
            end else begin
                held[c]     = data_out_valid[c];
                last_out[c] = lane_out;
            end
            if (data_in_valid[c] && data_in_ready[c]) begin
                sent = send_q[c].pop_front();
                exp_q[c].push_back(expected_for(c, sent));
            end
            if (!exec && !exec_prev) begin
                check($sformatf("data_in_ready[%0d]", c), data_t'(data_in_ready[c]), '0);
            end
        end
        exec_prev = exec;
    endtask

    task automatic drain(input int mode);
        int n;
        n = 0;
        while (!lanes_empty()) begin
            step(mode, 1'b1);
            n++;
            if (n > TIMEOUT) begin
                fail_run("timeout: lanes did not drain all queued words");
            end
        end
        // any word left in the mesh now is a duplicate
        repeat (ROWS) step(READY_ALL, 1'b1);
    endtask

    task automatic queue_rows();
        for (int i = 0; i < N_ROWS_TAB; i++) begin
            send_q[row_lane[i]].push_back(row_value[i]);
        end
    endtask

    task automatic queue_random(input int n);
        for (int i = 0; i < n; i++) begin
            for (int c = 0; c < COLS; c++) begin
                send_q[c].push_back(data_t'(rand_bits(DATA_W)));
            end
        end
    endtask

    initial begin
        rst              = 1'b1;
        bitstream_enable = 1'b0;
        cfg_word         = '0;
        cfg_valid        = 1'b0;
        execute          = 1'b0;
        data_in          = '0;
        data_in_valid    = '0;
        data_out_ready   = '0;
        exec_prev        = 1'b0;
        for (int c = 0; c < COLS; c++) begin
            held[c]     = 1'b0;
            last_out[c] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (3) begin
            @(negedge clk);
            check("cfg_done", data_t'(cfg_done), '0);
            check("data_in_ready", data_t'(data_in_ready), '0);
            check("data_out_valid", data_t'(data_out_valid), '0);
        end

        load_config(0);

        // directed operands, then back-to-back random words
        queue_rows();
        drain(READY_ALL);
        queue_random(8);
        drain(READY_ALL);

        queue_random(12);
        drain(READY_RANDOM);

        // fill with the south edge stalled, then drop execute
        queue_random(6);
        repeat (10) step(READY_NONE, 1'b1);
        repeat (8) step(READY_ALL, 1'b0);
        check("data_out_valid", data_t'(data_out_valid), '0);
        drain(READY_RANDOM);

        load_config(1);
        queue_rows();
        queue_random(10);
        drain(READY_RANDOM);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
cgra_pkg.sv
cgra_cfg_fsm.sv
cgra_cfg_counter.sv
cgra_pe.sv
cgra_array.sv
cgra_top.sv
tb_cgra.sv

/* Makefile */
# Verilator build and run for the CGRA testbench

VERILATOR   ?= verilator
TOP         ?= tb_cgra
LINT_TOP    ?= cgra_top
FILELIST    ?= all.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= -Wno-fatal
BUILD_FLAGS ?= --binary --timing -j 0

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(LINT_TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
